//--- verilog/gpu_fetch_defines.svh
`ifndef GPU_FETCH_DEFINES_SVH
`define GPU_FETCH_DEFINES_SVH

// Warp and thread geometry
`define NUM_WARPS     4
`define NW_WIDTH      2
`define NUM_THREADS   4

// PC counts halfwords, bit 0 picks the halfword inside a word
`define PC_BITS       16

// Trace id carried alongside every fetch
`define UUID_WIDTH    8

// Instructions one warp's instruction buffer can hold
`define IBUF_SIZE     2

// Instruction ROM geometry and contents rule
`define ROM_ADDR_BITS 8
`define ROM_SALT      32'hA5C3_0F17

`endif

//--- verilog/gpu_fetch_pkg.sv
`default_nettype none

`include "gpu_fetch_defines.svh"

package gpu_fetch_pkg;

    typedef logic [`NW_WIDTH-1:0]              wid_t;
    typedef logic [`PC_BITS-1:0]               pc_t;
    typedef logic [`NUM_THREADS-1:0]           tmask_t;
    typedef logic [`UUID_WIDTH-1:0]            uuid_t;
    typedef logic [`PC_BITS-2:0]               word_addr_t;
    typedef logic [31:0]                       instr_t;

    // Uuid in the upper bits, warp id in the lower bits
    typedef logic [`UUID_WIDTH+`NW_WIDTH-1:0]  icache_tag_t;

    // Scheduler to fetch, 30 bits
    typedef struct packed {
        uuid_t  uuid;
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } schedule_data_t;

    // Fetch to instruction memory, 25 bits
    typedef struct packed {
        word_addr_t  addr;
        icache_tag_t tag;
    } icache_req_t;

    // Instruction memory back to fetch, 42 bits
    typedef struct packed {
        instr_t      instr;
        icache_tag_t tag;
    } icache_rsp_t;

    // Fetch to instruction buffer, 62 bits
    typedef struct packed {
        uuid_t  uuid;
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
        instr_t instr;
    } fetch_data_t;

endpackage

`default_nettype wire

//--- verilog/fetch_tag_store.sv
`default_nettype none

`include "gpu_fetch_defines.svh"

module fetch_tag_store (
    input  logic                  clk,
    input  logic                  write,
    input  gpu_fetch_pkg::wid_t   waddr,
    input  gpu_fetch_pkg::pc_t    wpc,
    input  gpu_fetch_pkg::tmask_t wtmask,
    input  gpu_fetch_pkg::wid_t   raddr,
    output gpu_fetch_pkg::pc_t    rpc,
    output gpu_fetch_pkg::tmask_t rtmask
);
    import gpu_fetch_pkg::*;

    // One entry per warp, plain registers so the read is asynchronous
    pc_t    pc_mem    [`NUM_WARPS];
    tmask_t tmask_mem [`NUM_WARPS];

    always_ff @(posedge clk) begin
        if (write) begin
            pc_mem[waddr]    <= wpc;
            tmask_mem[waddr] <= wtmask;
        end
    end

    // Response tag looks up the entry in the same cycle
    assign rpc    = pc_mem[raddr];
    assign rtmask = tmask_mem[raddr];

endmodule

`default_nettype wire

//--- verilog/pending_fetch_counter.sv
`default_nettype none

`include "gpu_fetch_defines.svh"

module pending_fetch_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic incr,
    input  logic decr,
    output logic full
);

    localparam int CNT_W = $clog2(`IBUF_SIZE + 1);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_n;

    // Fetches issued for this warp that have not left its instruction buffer
    always_comb begin
        count_n = count;
        if (incr && !decr) begin
            if (count != CNT_W'(`IBUF_SIZE)) begin
                count_n = count + 1'b1;
            end
        end else if (decr && !incr) begin
            if (count != '0) begin
                count_n = count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            full  <= 1'b0;
        end else begin
            count <= count_n;
            // Flag tracks the stored count without a compare on the output
            full  <= (count_n == CNT_W'(`IBUF_SIZE));
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_skid_buffer.sv
`default_nettype none

module fetch_skid_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    output logic                       ready_in,
    input  gpu_fetch_pkg::icache_req_t data_in,
    output logic                       valid_out,
    output gpu_fetch_pkg::icache_req_t data_out,
    input  logic                       ready_out
);
    import gpu_fetch_pkg::*;

    logic        main_valid;
    logic        skid_valid;
    icache_req_t main_data;
    icache_req_t skid_data;
    logic        push;

    // Only accept while the skid slot is free, so the ready is a flop output
    assign ready_in = ~skid_valid;
    assign push     = valid_in && ready_in;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (skid_valid) begin
                // Drain the skid entry into the output register
                if (ready_out) begin
                    skid_valid <= 1'b0;
                end
            end else if (push) begin
                if (!main_valid || ready_out) begin
                    main_valid <= 1'b1;
                end else begin
                    skid_valid <= 1'b1;
                end
            end else if (ready_out) begin
                main_valid <= 1'b0;
            end
        end
    end

    // Payload registers follow the same decisions as the valid bits
    always_ff @(posedge clk) begin
        if (skid_valid) begin
            if (ready_out) begin
                main_data <= skid_data;
            end
        end else if (push) begin
            if (!main_valid || ready_out) begin
                main_data <= data_in;
            end else begin
                skid_data <= data_in;
            end
        end
    end

    assign valid_out = main_valid;
    assign data_out  = main_data;

endmodule

`default_nettype wire

//--- verilog/warp_fetch.sv
`default_nettype none

`include "gpu_fetch_defines.svh"

module warp_fetch (
    input  logic                          clk,
    input  logic                          rst_n,

    // Schedule stream from the warp scheduler
    input  logic                          schedule_valid,
    input  gpu_fetch_pkg::schedule_data_t schedule_data,
    output logic                          schedule_ready,

    // Instruction memory request
    output logic                          icache_req_valid,
    output gpu_fetch_pkg::icache_req_t    icache_req_data,
    input  logic                          icache_req_ready,

    // Instruction memory response
    input  logic                          icache_rsp_valid,
    input  gpu_fetch_pkg::icache_rsp_t    icache_rsp_data,
    output logic                          icache_rsp_ready,

    // Fetch stream to the instruction buffer
    output logic                          fetch_valid,
    output gpu_fetch_pkg::fetch_data_t    fetch_data,
    input  logic                          fetch_ready,

    input  logic [`NUM_WARPS-1:0]         ibuf_pop
);
    import gpu_fetch_pkg::*;

    logic [`NUM_WARPS-1:0] pending_full;
    logic                  ibuf_ready;
    logic                  req_in_ready;
    logic                  schedule_fire;
    icache_req_t           req_in;

    uuid_t                 rsp_uuid;
    wid_t                  rsp_wid;
    pc_t                   rsp_pc;
    tmask_t                rsp_tmask;

    // Hold back a warp whose instruction buffer could overflow
    assign ibuf_ready     = ~pending_full[schedule_data.wid];
    assign schedule_ready = req_in_ready && ibuf_ready;
    assign schedule_fire  = schedule_valid && schedule_ready;

    assign req_in.addr = schedule_data.pc[`PC_BITS-1:1];
    assign req_in.tag  = {schedule_data.uuid, schedule_data.wid};

    fetch_tag_store tag_store (
        .clk    (clk),
        .write  (schedule_fire),
        .waddr  (schedule_data.wid),
        .wpc    (schedule_data.pc),
        .wtmask (schedule_data.tmask),
        .raddr  (rsp_wid),
        .rpc    (rsp_pc),
        .rtmask (rsp_tmask)
    );

    for (genvar i = 0; i < `NUM_WARPS; i++) begin : g_pending
        pending_fetch_counter pending (
            .clk   (clk),
            .rst_n (rst_n),
            .incr  (schedule_fire && (schedule_data.wid == wid_t'(i))),
            .decr  (ibuf_pop[i]),
            .full  (pending_full[i])
        );
    end

    // Registered toward the memory side
    fetch_skid_buffer req_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (schedule_valid && ibuf_ready),
        .ready_in  (req_in_ready),
        .data_in   (req_in),
        .valid_out (icache_req_valid),
        .data_out  (icache_req_data),
        .ready_out (icache_req_ready)
    );

    // Rebuild the fetch record from the response tag
    assign {rsp_uuid, rsp_wid} = icache_rsp_data.tag;

    assign fetch_valid      = icache_rsp_valid;
    assign fetch_data.uuid  = rsp_uuid;
    assign fetch_data.wid   = rsp_wid;
    assign fetch_data.tmask = rsp_tmask;
    assign fetch_data.pc    = rsp_pc;
    assign fetch_data.instr = icache_rsp_data.instr;
    assign icache_rsp_ready = fetch_ready;

endmodule

`default_nettype wire

//--- verilog/instr_rom.sv
`default_nettype none

`include "gpu_fetch_defines.svh"

module instr_rom (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    input  gpu_fetch_pkg::icache_req_t req_data,
    output logic                       req_ready,
    output logic                       rsp_valid,
    output gpu_fetch_pkg::icache_rsp_t rsp_data,
    input  logic                       rsp_ready
);
    import gpu_fetch_pkg::*;

    logic                      req_fire;
    logic [`ROM_ADDR_BITS-1:0] rom_index;

    // Contents follow a fixed rule, word index XOR salt
    function automatic instr_t rom_word(input logic [`ROM_ADDR_BITS-1:0] index);
        instr_t word;
        word = '0;
        word[`ROM_ADDR_BITS-1:0] = index;
        return word ^ `ROM_SALT;
    endfunction

    // Upper word address bits alias onto the ROM
    assign rom_index = req_data.addr[`ROM_ADDR_BITS-1:0];

    // Accept when the response slot is empty or leaving this cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_data.instr <= rom_word(rom_index);
            rsp_data.tag   <= req_data.tag;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_subsystem.sv
`default_nettype none

`include "gpu_fetch_defines.svh"

module fetch_subsystem (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          schedule_valid,
    input  gpu_fetch_pkg::schedule_data_t schedule_data,
    output logic                          schedule_ready,

    output logic                          fetch_valid,
    output gpu_fetch_pkg::fetch_data_t    fetch_data,
    input  logic                          fetch_ready,

    input  logic [`NUM_WARPS-1:0]         ibuf_pop
);
    import gpu_fetch_pkg::*;

    // Instruction memory bus between fetch and ROM
    logic        icache_req_valid;
    icache_req_t icache_req_data;
    logic        icache_req_ready;
    logic        icache_rsp_valid;
    icache_rsp_t icache_rsp_data;
    logic        icache_rsp_ready;

    warp_fetch fetch (
        .clk              (clk),
        .rst_n            (rst_n),
        .schedule_valid   (schedule_valid),
        .schedule_data    (schedule_data),
        .schedule_ready   (schedule_ready),
        .icache_req_valid (icache_req_valid),
        .icache_req_data  (icache_req_data),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_data  (icache_rsp_data),
        .icache_rsp_ready (icache_rsp_ready),
        .fetch_valid      (fetch_valid),
        .fetch_data       (fetch_data),
        .fetch_ready      (fetch_ready),
        .ibuf_pop         (ibuf_pop)
    );

    instr_rom rom (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (icache_req_valid),
        .req_data  (icache_req_data),
        .req_ready (icache_req_ready),
        .rsp_valid (icache_rsp_valid),
        .rsp_data  (icache_rsp_data),
        .rsp_ready (icache_rsp_ready)
    );

endmodule

`default_nettype wire

//--- sim/fetch_subsystem_tb.sv
`default_nettype none

`include "gpu_fetch_defines.svh"

module fetch_subsystem_tb;
    import gpu_fetch_pkg::*;

    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = 20 * NUM_ROWS + 100;

    // One fetch per row
    typedef struct {
        string                 name;
        wid_t                  wid;
        pc_t                   pc;
        tmask_t                tmask;
        uuid_t                 uuid;
        logic [`NUM_WARPS-1:0] pop;
        bit                    rand_ready;
        bit                    wait_prev;
        bit                    probe_full;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  schedule_valid;
    schedule_data_t        schedule_data;
    logic                  schedule_ready;
    logic                  fetch_valid;
    fetch_data_t           fetch_data;
    logic                  fetch_ready;
    logic [`NUM_WARPS-1:0] ibuf_pop;

    row_t                  rows [NUM_ROWS];

    // Outstanding fetches in issue order
    int                    exp_row [$];
    int                    exp_cyc [$];

    int                    pend [`NUM_WARPS];
    logic [`NUM_WARPS-1:0] inflight;
    int                    cycle = 0;
    int                    edge_cycle;
    int                    errors = 0;
    int                    fetched = 0;
    logic [31:0]           lfsr = 32'd84436;
    bit                    ready_random = 1'b0;
    bit                    holding = 1'b0;
    fetch_data_t           held;
    logic                  ready_seen;
    logic                  valid_seen;
    logic                  sched_fire;

    fetch_subsystem uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .schedule_valid (schedule_valid),
        .schedule_data  (schedule_data),
        .schedule_ready (schedule_ready),
        .fetch_valid    (fetch_valid),
        .fetch_data     (fetch_data),
        .fetch_ready    (fetch_ready),
        .ibuf_pop       (ibuf_pop)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d fetches never arrived", cycle,
                     exp_row.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic random_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic fetch_data_t expected_record(input int idx);
        fetch_data_t rec;
        rec.uuid  = rows[idx].uuid;
        rec.wid   = rows[idx].wid;
        rec.tmask = rows[idx].tmask;
        rec.pc    = rows[idx].pc;
        // ROM word is the low word-address bits XOR the salt
        rec.instr = 32'(rows[idx].pc[`ROM_ADDR_BITS:1]) ^ `ROM_SALT;
        return rec;
    endfunction

    task automatic set_row(input int i, input string name, input wid_t wid, input pc_t pc,
                           input tmask_t tmask, input uuid_t uuid,
                           input logic [`NUM_WARPS-1:0] pop, input bit rnd,
                           input bit wait_prev, input bit probe);
        rows[i].name       = name;
        rows[i].wid        = wid;
        rows[i].pc         = pc;
        rows[i].tmask      = tmask;
        rows[i].uuid       = uuid;
        rows[i].pop        = pop;
        rows[i].rand_ready = rnd;
        rows[i].wait_prev  = wait_prev;
        rows[i].probe_full = probe;
    endtask

    task automatic fill_table();
        // Single fetches, one warp at a time
        set_row(0, "single_w0", 2'd0, 16'h0010, 4'hF, 8'h01, 4'b0000, 1'b0, 1'b1, 1'b0);
        set_row(1, "single_w1", 2'd1, 16'h0123, 4'h3, 8'h02, 4'b0001, 1'b0, 1'b1, 1'b0);
        set_row(2, "single_w2", 2'd2, 16'h01FE, 4'h5, 8'h03, 4'b0010, 1'b0, 1'b1, 1'b0);
        set_row(3, "single_w3", 2'd3, 16'hFFFF, 4'h8, 8'h04, 4'b0100, 1'b0, 1'b1, 1'b0);
        // Back to back over all warps
        set_row(4, "b2b_w0", 2'd0, 16'h0200, 4'h1, 8'h10, 4'b1000, 1'b0, 1'b1, 1'b0);
        set_row(5, "b2b_w1", 2'd1, 16'h0202, 4'h2, 8'h11, 4'b0000, 1'b0, 1'b0, 1'b0);
        set_row(6, "b2b_w2", 2'd2, 16'h0204, 4'h4, 8'h12, 4'b0000, 1'b0, 1'b0, 1'b0);
        set_row(7, "b2b_w3", 2'd3, 16'h0206, 4'h8, 8'h13, 4'b0000, 1'b0, 1'b0, 1'b0);
        // Random back-pressure on the fetch output
        set_row(8, "rand_w0", 2'd0, 16'h1000, 4'hC, 8'h20, 4'b1111, 1'b1, 1'b1, 1'b0);
        set_row(9, "rand_w1", 2'd1, 16'h1002, 4'hA, 8'h21, 4'b0000, 1'b1, 1'b0, 1'b0);
        set_row(10, "rand_w2", 2'd2, 16'h3457, 4'h6, 8'h22, 4'b0000, 1'b1, 1'b0, 1'b0);
        set_row(11, "rand_w3", 2'd3, 16'h2AAA, 4'h9, 8'h23, 4'b0000, 1'b1, 1'b0, 1'b0);
        // Fill warp 0's buffer, then free one slot
        set_row(12, "fill_w0_a", 2'd0, 16'h0400, 4'hF, 8'h30, 4'b1111, 1'b0, 1'b1, 1'b0);
        set_row(13, "fill_w0_b", 2'd0, 16'h0402, 4'h7, 8'h31, 4'b0000, 1'b0, 1'b1, 1'b0);
        set_row(14, "limit_w0", 2'd0, 16'h0404, 4'h1, 8'h32, 4'b0001, 1'b0, 1'b1, 1'b1);
        set_row(15, "after_limit_w1", 2'd1, 16'h0500, 4'h6, 8'h33, 4'b0000, 1'b0, 1'b0,
                1'b0);
    endtask

    // Runs at the rising edge, before any register updates land
    task automatic check_fetch();
        fetch_data_t exp_rec;
        int          idx;
        int          lat;
        if (holding && (!fetch_valid || fetch_data !== held)) begin
            errors++;
            $display("Fetch output changed while stalled, held %h, now valid %0b data %h",
                     held, fetch_valid, fetch_data);
        end
        if (fetch_valid && fetch_ready) begin
            holding = 1'b0;
            fetched++;
            if (exp_row.size() == 0) begin
                errors++;
                $display("Fetch record %h arrived with no fetch outstanding", fetch_data);
            end else begin
                idx     = exp_row.pop_front();
                lat     = edge_cycle - exp_cyc.pop_front();
                exp_rec = expected_record(idx);
                inflight[rows[idx].wid] = 1'b0;
                if (fetch_data !== exp_rec) begin
                    errors++;
                    $display("[FAIL] %s: expected %h, actual %h", rows[idx].name, exp_rec,
                             fetch_data);
                end
                if (!rows[idx].rand_ready && lat != 2) begin
                    errors++;
                    $display("[FAIL] %s latency: expected 2, actual %0d", rows[idx].name, lat);
                end
            end
        end else begin
            holding = fetch_valid;
            held    = fetch_data;
        end
    endtask

    // One clock: sample at the rising edge, drive at the falling edge
    task automatic step();
        @(posedge clk);
        edge_cycle = cycle;
        ready_seen = schedule_ready;
        valid_seen = fetch_valid;
        sched_fire = schedule_valid && schedule_ready;
        if (rst_n) begin
            check_fetch();
        end
        @(negedge clk);
        ibuf_pop = '0;
        if (ready_random) begin
            fetch_ready = random_bit();
        end else begin
            fetch_ready = 1'b1;
        end
    endtask

    task automatic drain();
        while (exp_row.size() != 0) begin
            step();
        end
    endtask

    task automatic wait_warp_idle(input wid_t wid);
        while (inflight[wid]) begin
            step();
        end
    endtask

    // Look at schedule_ready for a warp without offering a fetch
    task automatic probe_ready(input int idx, input wid_t wid);
        logic exp_ready;
        exp_ready         = (pend[wid] < `IBUF_SIZE);
        schedule_valid    = 1'b0;
        schedule_data.wid = wid;
        step();
        if (ready_seen !== exp_ready) begin
            errors++;
            $display("[FAIL] %s ready for warp %0d: expected %0b, actual %0b", rows[idx].name,
                     wid, exp_ready, ready_seen);
        end
    endtask

    task automatic apply_pops(input logic [`NUM_WARPS-1:0] pop);
        ibuf_pop = pop;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            if (pop[w] && pend[w] > 0) begin
                pend[w]--;
            end
        end
        step();
    endtask

    task automatic issue_row(input int idx, input bit expect_now);
        int waited;
        waited              = 0;
        schedule_data.uuid  = rows[idx].uuid;
        schedule_data.wid   = rows[idx].wid;
        schedule_data.tmask = rows[idx].tmask;
        schedule_data.pc    = rows[idx].pc;
        schedule_valid      = 1'b1;
        step();
        while (!sched_fire) begin
            waited++;
            step();
        end
        exp_row.push_back(idx);
        exp_cyc.push_back(edge_cycle);
        inflight[rows[idx].wid] = 1'b1;
        pend[rows[idx].wid]++;
        schedule_valid = 1'b0;
        if (expect_now && waited != 0) begin
            errors++;
            $display("[FAIL] %s accept wait: expected 0, actual %0d", rows[idx].name, waited);
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        schedule_valid = 1'b0;
        schedule_data  = '0;
        fetch_ready    = 1'b1;
        ibuf_pop       = '0;
        inflight       = '0;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            pend[w] = 0;
        end
        fill_table();
        repeat (3) step();
        rst_n = 1'b1;
        step();
        if (valid_seen !== 1'b0) begin
            errors++;
            $display("[FAIL] reset fetch_valid: expected 0, actual %0b", valid_seen);
        end
        if (ready_seen !== 1'b1) begin
            errors++;
            $display("[FAIL] reset schedule_ready: expected 1, actual %0b", ready_seen);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].wait_prev) begin
                drain();
            end
            wait_warp_idle(rows[i].wid);
            ready_random = rows[i].rand_ready;
            if (rows[i].probe_full) begin
                probe_ready(i, rows[i].wid);
                probe_ready(i, rows[i].wid + 1'b1);
            end
            if (rows[i].pop != '0) begin
                apply_pops(rows[i].pop);
            end
            issue_row(i, rows[i].wait_prev && pend[rows[i].wid] < `IBUF_SIZE);
        end
        ready_random = 1'b0;
        drain();
        $display("Done: %0d errors, %0d of %0d fetches received", errors, fetched, NUM_ROWS);
        if (errors == 0 && fetched == NUM_ROWS) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_subsystem.f
+incdir+verilog
verilog/gpu_fetch_pkg.sv
verilog/fetch_tag_store.sv
verilog/pending_fetch_counter.sv
verilog/fetch_skid_buffer.sv
verilog/warp_fetch.sv
verilog/instr_rom.sv
verilog/fetch_subsystem.sv
sim/fetch_subsystem_tb.sv

//--- Makefile
# Verilator build and run for the fetch subsystem

VERILATOR ?= verilator
TOP       ?= fetch_subsystem_tb
RTL_TOP   ?= fetch_subsystem
FILELIST  ?= fetch_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
